//--- testbench/pipelineTrace.txt
// First line: program word count, expected writeback count
// Then the program words, then one line per writeback: register (hex), value
0000001b 00000018
06400093 ff900113 002081b3 40208233
0041f2b3 0041e333 0041c3b3 00111433
001154b3 40115533 001125b3 00113633
ff017693 f000e713 fff0c793 ffa12813
01409893 01c15913 40115993 faf0a223
00802a03 003a0ab3 00508013 01500b33
01602623 00c02b83 41708c33
01 00000064
02 fffffff9
03 0000005d
04 0000006b
05 00000049
06 0000007f
07 00000036
08 ffffff90
09 0fffffff
0a ffffffff
0b 00000001
0c 00000000
0d fffffff0
0e ffffff64
0f ffffff9b
10 00000001
11 06400000
12 0000000f
13 fffffffc
14 ffffff9b
15 fffffff8
16 fffffff8
17 fffffff8
18 0000006c

//--- vlog.f
verilog/rvPkg.sv
verilog/fetchDecode.sv
verilog/hazardForward.sv
verilog/aluExecute.sv
verilog/memWriteback.sv
verilog/rvPipeline.sv
testbench/tbClock.sv
testbench/rvPipeline_sva.sv
testbench/rvPipelineTb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of rvPipelineTb

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rvPipelineTb -o rvPipelineSim -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvPipelineSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -F -q "*** TEST PASSED ***" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

//--- testbench/rvPipelineTb.sv
`timescale 1ns/1ns

module rvPipelineTb import rvPkg::*; ();

    localparam int imemBits    = 6;
    localparam int resetCycles = 16;
    localparam int drainCycles = 20;

    logic                clk;
    logic                rst;
    logic                run;
    logic                progWrite;
    logic [imemBits-1:0] progAddr;
    word_t               progData;
    logic                wbValid;
    regAddr_t            wbReg;
    word_t               wbData;

    // Header word pair, program words, then register/value pairs
    word_t traceMem [256];
    int    progCount;
    int    expCount;
    int    progIndex;
    int    matchCount = 0;
    int    cycleCount = 0;
    int    cycleLimit;
    word_t expReg;
    word_t expData;

    tbClock clockGen (.clk(clk));

    rvPipeline #(.imemAddrBits(imemBits), .dmemAddrBits(6)) UUT (
        .clk(clk), .rst(rst), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        $readmemh("testbench/pipelineTrace.txt", traceMem);
        progCount = int'(traceMem[0]);
        expCount  = int'(traceMem[1]);
        assert (progCount > 0 && progCount <= 2**imemBits && expCount > 0 && expCount <= 64)
            else abortRun("Trace header holds an invalid program or result count");
        cycleLimit = resetCycles + progCount + 8 * expCount + 64;

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        // One word per cycle, core still halted
        for (progIndex = 0; progIndex < progCount; progIndex++) begin
            progWrite <= 1'b1;
            progAddr  <= imemBits'(progIndex);
            progData  <= traceMem[2 + progIndex];
            @(posedge clk);
        end
        progWrite <= 1'b0;
        run       <= 1'b1;

        wait (matchCount == expCount);
        // Any late pulse here is caught by the checker
        repeat (drainCycles) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Writeback checker
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && wbValid) begin
            assert (matchCount < expCount)
                else abortRun($sformatf("Unexpected writeback to x%0d at %0t after the last result",
                                        wbReg, $time));
            expReg  = traceMem[2 + progCount + 2 * matchCount];
            expData = traceMem[3 + progCount + 2 * matchCount];
            assert (wbReg === expReg[4:0])
                else abortRun($sformatf("Mismatch at %0t: wbReg expected %0d, got %0d",
                                        $time, expReg, wbReg));
            assert (wbData === expData)
                else abortRun($sformatf("Mismatch at %0t: wbData expected %h, got %h",
                                        $time, expData, wbData));
            matchCount = matchCount + 1;
        end
    end

    // Cycle budget
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("Timeout: only %0d of %0d writebacks seen within %0d cycles",
                               matchCount, expCount, cycleLimit));
        end
    end

endmodule

//--- testbench/rvPipeline_sva.sv
`timescale 1ns/1ns

module rvPipeline_sva import rvPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     wbValid,
    input regAddr_t wbReg,
    input word_t    wbData
);

    // Covers reset from its second cycle on and the cycle after release
    wbQuietAroundReset: assert property (@(posedge clk) rst |=> !wbValid)
        else $error("wbValid high during reset or in the cycle after it");

    wbRegNonZero: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbReg != '0)
        else $error("Writeback pulse addresses x0");

    wbDataKnown: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> !$isunknown(wbData))
        else $error("Writeback data unknown while wbValid is high");

endmodule

bind rvPipeline rvPipeline_sva wbChecks (
    .clk(clk),
    .rst(rst),
    .wbValid(wbValid),
    .wbReg(wbReg),
    .wbData(wbData)
);

//--- testbench/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

//--- verilog/rvPipeline.sv
`timescale 1ns/1ns

module rvPipeline import rvPkg::*; #(
    parameter int imemAddrBits = 6,
    parameter int dmemAddrBits = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    progWrite,
    input  logic [imemAddrBits-1:0] progAddr,
    input  word_t                   progData,
    output logic                    wbValid,
    output regAddr_t                wbReg,
    output word_t                   wbData
);

    regAddr_t idRs1, idRs2, decRs1, decRs2, decRd;
    logic decRegWrite, decMemRead, decMemWrite, decAluSrcImm;
    aluSel_t decAluSel;
    word_t decRs1Val, decRs2Val, decImm;
    logic stall;
    fwdSel_t forwardA, forwardB;
    regAddr_t exRd, exRs1, exRs2, memRd;
    logic exMemRead, memRegWrite, memMemRead, memMemWrite;
    word_t memResult, memStoreData;
    logic wbRegWrite;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    fetchDecode #(.imemAddrBits(imemAddrBits)) fetchDecodeInst (
        .clk(clk), .rst(rst), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .stall(stall),
        .wbWrite(wbRegWrite), .wbRd(wbReg), .wbValue(wbData),
        .idRs1(idRs1), .idRs2(idRs2),
        .decRegWrite(decRegWrite), .decMemRead(decMemRead),
        .decMemWrite(decMemWrite), .decAluSrcImm(decAluSrcImm),
        .decAluSel(decAluSel),
        .decRs1Val(decRs1Val), .decRs2Val(decRs2Val), .decImm(decImm),
        .decRs1(decRs1), .decRs2(decRs2), .decRd(decRd)
    );

    hazardForward hazardForwardInst (
        .idRs1(idRs1), .idRs2(idRs2),
        .exRd(exRd), .memRd(memRd), .wbRd(wbReg),
        .exMemRead(exMemRead), .memRegWrite(memRegWrite), .wbRegWrite(wbRegWrite),
        .exRs1(exRs1), .exRs2(exRs2),
        .stall(stall), .forwardA(forwardA), .forwardB(forwardB)
    );

    aluExecute aluExecuteInst (
        .clk(clk), .rst(rst),
        .decRegWrite(decRegWrite), .decMemRead(decMemRead),
        .decMemWrite(decMemWrite), .decAluSrcImm(decAluSrcImm),
        .decAluSel(decAluSel),
        .decRs1Val(decRs1Val), .decRs2Val(decRs2Val), .decImm(decImm),
        .decRs1(decRs1), .decRs2(decRs2), .decRd(decRd),
        .forwardA(forwardA), .forwardB(forwardB), .wbValue(wbData),
        .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2), .exMemRead(exMemRead),
        .memResult(memResult), .memStoreData(memStoreData),
        .memRd(memRd), .memRegWrite(memRegWrite),
        .memMemRead(memMemRead), .memMemWrite(memMemWrite)
    );

    memWriteback #(.dmemAddrBits(dmemAddrBits)) memWritebackInst (
        .clk(clk), .rst(rst),
        .memResult(memResult), .memStoreData(memStoreData), .memRd(memRd),
        .memRegWrite(memRegWrite), .memMemRead(memMemRead), .memMemWrite(memMemWrite),
        .wbRegWrite(wbRegWrite), .wbValid(wbValid), .wbRd(wbReg), .wbValue(wbData)
    );

endmodule

//--- verilog/memWriteback.sv
`timescale 1ns/1ns

module memWriteback import rvPkg::*; #(
    parameter int dmemAddrBits = 6
) (
    input  logic     clk,
    input  logic     rst,
    input  word_t    memResult,
    input  word_t    memStoreData,
    input  regAddr_t memRd,
    input  logic     memRegWrite,
    input  logic     memMemRead,
    input  logic     memMemWrite,
    output logic     wbRegWrite,
    output logic     wbValid,
    output regAddr_t wbRd,
    output word_t    wbValue
);

    word_t dmem [2**dmemAddrBits];
    logic [dmemAddrBits-1:0] dataAddr;
    word_t loadWord;
    logic wbIsLoad;
    word_t wbLoadData, wbAluResult;

    // Word index from the byte address
    assign dataAddr = memResult[dmemAddrBits+1:2];
    assign loadWord = dmem[dataAddr];

    always_ff @(posedge clk) begin
        if (memMemWrite) begin
            dmem[dataAddr] <= memStoreData;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
            wbIsLoad   <= 1'b0;
            wbRd       <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbIsLoad   <= memMemRead;
            wbRd       <= memRd;
        end
    end

    always_ff @(posedge clk) begin
        wbLoadData  <= loadWord;
        wbAluResult <= memResult;
    end

    assign wbValue = wbIsLoad ? wbLoadData : wbAluResult;
    // No pulse for x0
    assign wbValid = wbRegWrite && wbRd != '0;

endmodule

//--- verilog/aluExecute.sv
`timescale 1ns/1ns

module aluExecute import rvPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     decRegWrite,
    input  logic     decMemRead,
    input  logic     decMemWrite,
    input  logic     decAluSrcImm,
    input  aluSel_t  decAluSel,
    input  word_t    decRs1Val,
    input  word_t    decRs2Val,
    input  word_t    decImm,
    input  regAddr_t decRs1,
    input  regAddr_t decRs2,
    input  regAddr_t decRd,
    input  fwdSel_t  forwardA,
    input  fwdSel_t  forwardB,
    input  word_t    wbValue,
    output regAddr_t exRd,
    output regAddr_t exRs1,
    output regAddr_t exRs2,
    output logic     exMemRead,
    output word_t    memResult,
    output word_t    memStoreData,
    output regAddr_t memRd,
    output logic     memRegWrite,
    output logic     memMemRead,
    output logic     memMemWrite
);

    logic exRegWrite, exMemWrite, exAluSrcImm;
    aluSel_t exAluSel;
    word_t exRs1Val, exRs2Val, exImm;
    word_t opA, opB, aluB, aluOut;
    logic [4:0] shamt;

    function automatic word_t fwdMux(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   exMemVal,
        input word_t   memWbVal
    );
        word_t val;
        case (sel)
            fwdExMem: val = exMemVal;
            fwdMemWb: val = memWbVal;
            default:  val = regVal;
        endcase
        return val;
    endfunction

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRd       <= '0;
            exRs1      <= '0;
            exRs2      <= '0;
        end else begin
            exRegWrite <= decRegWrite;
            exMemRead  <= decMemRead;
            exMemWrite <= decMemWrite;
            exRd       <= decRd;
            exRs1      <= decRs1;
            exRs2      <= decRs2;
        end
    end

    always_ff @(posedge clk) begin
        exAluSrcImm <= decAluSrcImm;
        exAluSel    <= decAluSel;
        exRs1Val    <= decRs1Val;
        exRs2Val    <= decRs2Val;
        exImm       <= decImm;
    end

    //////////////////////////////////////////////////
    // Operands and ALU
    //////////////////////////////////////////////////

    assign opA = fwdMux(forwardA, exRs1Val, memResult, wbValue);
    assign opB = fwdMux(forwardB, exRs2Val, memResult, wbValue);

    // Immediate for OP-IMM, loads and stores
    assign aluB  = exAluSrcImm ? exImm : opB;
    assign shamt = aluB[4:0];

    always_comb begin
        case (exAluSel)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            aluXor:  aluOut = opA ^ aluB;
            aluSll:  aluOut = opA << shamt;
            aluSrl:  aluOut = opA >> shamt;
            aluSra:  aluOut = $signed(opA) >>> shamt;
            aluSlt:  aluOut = word_t'($signed(opA) < $signed(aluB));
            aluSltu: aluOut = word_t'(opA < aluB);
            default: aluOut = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memRd       <= '0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memRd       <= exRd;
        end
    end

    always_ff @(posedge clk) begin
        memResult    <= aluOut;
        memStoreData <= opB;
    end

endmodule

//--- verilog/hazardForward.sv
`timescale 1ns/1ns

module hazardForward import rvPkg::*; (
    input  regAddr_t idRs1,
    input  regAddr_t idRs2,
    input  regAddr_t exRd,
    input  regAddr_t memRd,
    input  regAddr_t wbRd,
    input  logic     exMemRead,
    input  logic     memRegWrite,
    input  logic     wbRegWrite,
    input  regAddr_t exRs1,
    input  regAddr_t exRs2,
    output logic     stall,
    output fwdSel_t  forwardA,
    output fwdSel_t  forwardB
);

    logic loadInEx;

    // Youngest producer wins, x0 is never forwarded
    function automatic fwdSel_t pickSource(
        input regAddr_t src,
        input regAddr_t memDst,
        input logic     memWr,
        input regAddr_t wbDst,
        input logic     wbWr
    );
        fwdSel_t sel;
        if (src == '0) begin
            sel = fwdRegFile;
        end else if (memWr && memDst == src) begin
            sel = fwdExMem;
        end else if (wbWr && wbDst == src) begin
            sel = fwdMemWb;
        end else begin
            sel = fwdRegFile;
        end
        return sel;
    endfunction

    // Load result is not ready until after MEM
    assign loadInEx = exMemRead && exRd != '0;
    assign stall    = loadInEx && (exRd == idRs1 || exRd == idRs2);

    assign forwardA = pickSource(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
    assign forwardB = pickSource(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

endmodule

//--- verilog/fetchDecode.sv
`timescale 1ns/1ns

module fetchDecode import rvPkg::*; #(
    parameter int imemAddrBits = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    progWrite,
    input  logic [imemAddrBits-1:0] progAddr,
    input  word_t                   progData,
    input  logic                    stall,
    input  logic                    wbWrite,
    input  regAddr_t                wbRd,
    input  word_t                   wbValue,
    output regAddr_t                idRs1,
    output regAddr_t                idRs2,
    output logic                    decRegWrite,
    output logic                    decMemRead,
    output logic                    decMemWrite,
    output logic                    decAluSrcImm,
    output aluSel_t                 decAluSel,
    output word_t                   decRs1Val,
    output word_t                   decRs2Val,
    output word_t                   decImm,
    output regAddr_t                decRs1,
    output regAddr_t                decRs2,
    output regAddr_t                decRd
);

    // Word-addressed PC
    logic [imemAddrBits-1:0] pc;
    word_t imem [2**imemAddrBits];
    word_t ifIdInst;
    logic ifIdValid;
    word_t regs [32];

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic issue;
    logic regWrite, memRead, memWrite, aluSrcImm;
    logic usesRs1, usesRs2;
    aluSel_t aluSel;

    function automatic aluSel_t aluSelect(input logic [2:0] f3, input logic alt);
        aluSel_t sel;
        case (f3)
            f3AddSub: sel = alt ? aluSub : aluAdd;
            f3Sll:    sel = aluSll;
            f3Slt:    sel = aluSlt;
            f3Sltu:   sel = aluSltu;
            f3Xor:    sel = aluXor;
            f3SrlSra: sel = alt ? aluSra : aluSrl;
            f3Or:     sel = aluOr;
            f3And:    sel = aluAnd;
            default:  sel = aluAdd;
        endcase
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // Fetch and IF/ID
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // Program loading only while the core is halted
    always_ff @(posedge clk) begin
        if (progWrite && !run) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            ifIdValid <= run;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdInst <= imem[pc];
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign opcode = ifIdInst[6:0];
    assign funct3 = ifIdInst[14:12];

    always_comb begin
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluSrcImm = 1'b0;
        usesRs1   = 1'b0;
        usesRs2   = 1'b0;
        aluSel    = aluAdd;
        case (opcode)
            opOp: begin
                regWrite = 1'b1;
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
                aluSel   = aluSelect(funct3, ifIdInst[30]);
            end
            opOpImm: begin
                regWrite  = 1'b1;
                usesRs1   = 1'b1;
                aluSrcImm = 1'b1;
                // Bit 30 only picks SRAI here, ADDI never subtracts
                aluSel    = aluSelect(funct3, ifIdInst[30] && funct3 == f3SrlSra);
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    regWrite  = 1'b1;
                    memRead   = 1'b1;
                    usesRs1   = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            opStore: begin
                if (funct3 == f3Word) begin
                    memWrite  = 1'b1;
                    usesRs1   = 1'b1;
                    usesRs2   = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Unused sources read as x0 so they never cause a stall or forward
    assign idRs1 = (ifIdValid && usesRs1) ? ifIdInst[19:15] : '0;
    assign idRs2 = (ifIdValid && usesRs2) ? ifIdInst[24:20] : '0;

    // Bubble on stall or while halted
    assign issue        = ifIdValid && !stall;
    assign decRegWrite  = issue && regWrite;
    assign decMemRead   = issue && memRead;
    assign decMemWrite  = issue && memWrite;
    assign decAluSrcImm = aluSrcImm;
    assign decAluSel    = aluSel;
    assign decRs1       = idRs1;
    assign decRs2       = idRs2;
    assign decRd        = decRegWrite ? ifIdInst[11:7] : '0;

    // S-type splits the immediate around rd
    assign decImm = (opcode == opStore) ?
                    {{20{ifIdInst[31]}}, ifIdInst[31:25], ifIdInst[11:7]} :
                    {{20{ifIdInst[31]}}, ifIdInst[31:20]};

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wbWrite && wbRd != '0) begin
            regs[wbRd] <= wbValue;
        end
    end

    // Write-through gives the same-cycle value to decode
    assign decRs1Val = (idRs1 == '0) ? '0 :
                       (wbWrite && wbRd == idRs1) ? wbValue : regs[idRs1];
    assign decRs2Val = (idRs2 == '0) ? '0 :
                       (wbWrite && wbRd == idRs2) ? wbValue : regs[idRs2];

endmodule

//--- verilog/rvPkg.sv
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluSel_t;
    typedef logic [1:0]  fwdSel_t;

    // Major opcodes
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Word width for LW and SW
    localparam logic [2:0] f3Word   = 3'b010;

    // ALU operation select
    localparam aluSel_t aluAdd  = 4'd0;
    localparam aluSel_t aluSub  = 4'd1;
    localparam aluSel_t aluAnd  = 4'd2;
    localparam aluSel_t aluOr   = 4'd3;
    localparam aluSel_t aluXor  = 4'd4;
    localparam aluSel_t aluSll  = 4'd5;
    localparam aluSel_t aluSrl  = 4'd6;
    localparam aluSel_t aluSra  = 4'd7;
    localparam aluSel_t aluSlt  = 4'd8;
    localparam aluSel_t aluSltu = 4'd9;

    // Execute operand source
    localparam fwdSel_t fwdRegFile = 2'd0;
    localparam fwdSel_t fwdExMem   = 2'd1;
    localparam fwdSel_t fwdMemWb   = 2'd2;

endpackage
